/* source/su_pkg.sv */
package su_pkg;

    // pe array geometry
    localparam int PE_ROWS  = 16;
    localparam int PE_COLS  = 16;
    localparam int PE_COUNT = PE_ROWS * PE_COLS;

    // data widths
    localparam int PSUM_W    = 16;
    localparam int GBF_W     = 512;
    localparam int GBF_LANES = GBF_W / PSUM_W;  // 32 lanes per buffer word

    // address and counter widths
    localparam int RF_ADDR_W  = 2;   // four psum rf addresses
    localparam int GBF_ADDR_W = 5;
    localparam int GBF_DEPTH  = 32;  // words per psum buffer
    localparam int BEAT_W     = 2;   // up to four beats per rf address

    typedef logic [PSUM_W-1:0] psum_t;
    typedef logic [GBF_W-1:0]  gbf_word_t;

    // reduction size, picked from irrel_num at the start of a run
    typedef enum logic [1:0] {
        GROUP_2 = 2'd0,
        GROUP_4 = 2'd1,
        GROUP_8 = 2'd2
    } group_mode_t;

endpackage

/* source/su_beat_sequencer.sv */
`timescale 1ns/1ps

module su_beat_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pe_psum_finish,
    input  logic [4:0]                 irrel_num,
    output logic                       busy,
    output logic [su_pkg::RF_ADDR_W-1:0] psum_rf_addr,
    output su_pkg::group_mode_t        group_mode,
    output logic                       issue_valid,
    output logic [su_pkg::BEAT_W-1:0]  issue_beat,
    output logic                       issue_last
);

    import su_pkg::*;

    logic              start_ok;     // irrel_num is a supported size
    group_mode_t       start_mode;
    logic              start;
    logic [BEAT_W-1:0] beat_cnt;
    logic [BEAT_W-1:0] beat_max;     // beats per rf address, minus one
    logic              beat_wrap;
    logic              addr_last;

    // decode of the reduction size
    always_comb begin
        start_ok   = 1'b1;
        start_mode = GROUP_2;
        case (irrel_num)
            5'd2: start_mode = GROUP_2;
            5'd4: start_mode = GROUP_4;
            5'd8: start_mode = GROUP_8;
            default: begin
                start_ok   = 1'b0;   // odd sizes are not handled here
                start_mode = GROUP_2;
            end
        endcase
    end

    // 128 pair sums take 4 words, 64 quads take 2, 32 octets take 1
    always_comb begin
        case (group_mode)
            GROUP_2: beat_max = BEAT_W'(3);
            GROUP_4: beat_max = BEAT_W'(1);
            GROUP_8: beat_max = BEAT_W'(0);
            default: beat_max = BEAT_W'(0);
        endcase
    end

    assign start     = pe_psum_finish && !busy && start_ok;  // pulses while busy are dropped
    assign beat_wrap = (beat_cnt == beat_max);
    assign addr_last = &psum_rf_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            psum_rf_addr <= '0;
            beat_cnt     <= '0;
            group_mode   <= GROUP_2;
        end else if (start) begin
            busy         <= 1'b1;
            psum_rf_addr <= '0;
            beat_cnt     <= '0;
            group_mode   <= start_mode;   // held for the whole run
        end else if (busy) begin
            if (beat_wrap) begin
                beat_cnt     <= '0;
                psum_rf_addr <= psum_rf_addr + 1'b1;  // 3 rolls back to 0
                if (addr_last) begin
                    busy <= 1'b0;
                end
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // one beat goes out on every busy cycle
    assign issue_valid = busy;
    assign issue_beat  = beat_cnt;
    assign issue_last  = busy && beat_wrap && addr_last;

endmodule

/* source/su_adder_tree.sv */
`timescale 1ns/1ps

module su_adder_tree (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [su_pkg::PE_COUNT*su_pkg::PSUM_W-1:0] psum_out,
    input  su_pkg::group_mode_t                      group_mode,
    input  logic                                     issue_valid,
    input  logic [su_pkg::BEAT_W-1:0]                issue_beat,
    input  logic                                     issue_last,
    output su_pkg::gbf_word_t                        lane_data,
    output logic                                     sum_valid,
    output logic                                     sum_last
);

    import su_pkg::*;

    psum_t     pe_psum   [PE_COUNT];
    psum_t     pair_sum  [PE_COUNT/2];
    psum_t     quad_sum  [PE_COUNT/4];
    psum_t     octet_sum [PE_COUNT/8];
    gbf_word_t lane_word;

    // pe i sits at bits i*16 of the flat bus
    for (genvar i = 0; i < PE_COUNT; i++) begin : g_unpack
        assign pe_psum[i] = psum_out[i*PSUM_W +: PSUM_W];
    end

    // level 1, neighbouring pes
    for (genvar p = 0; p < PE_COUNT/2; p++) begin : g_pair
        assign pair_sum[p] = pe_psum[2*p] + pe_psum[2*p+1];
    end

    // level 2 reuses the pair sums
    for (genvar q = 0; q < PE_COUNT/4; q++) begin : g_quad
        assign quad_sum[q] = pair_sum[2*q] + pair_sum[2*q+1];
    end

    // level 3 reuses the quad sums
    for (genvar o = 0; o < PE_COUNT/8; o++) begin : g_octet
        assign octet_sum[o] = quad_sum[2*o] + quad_sum[2*o+1];
    end

    // all sums wrap at 16 bits, same as the pe accumulators

    // lane j of beat k carries group k*32+j
    always_comb begin
        lane_word = '0;
        for (int j = 0; j < GBF_LANES; j++) begin
            case (group_mode)
                GROUP_2: begin
                    lane_word[j*PSUM_W +: PSUM_W] =
                        pair_sum[int'(issue_beat)*GBF_LANES + j];
                end
                GROUP_4: begin
                    lane_word[j*PSUM_W +: PSUM_W] =
                        quad_sum[int'(issue_beat[0])*GBF_LANES + j];  // two beats only
                end
                GROUP_8: begin
                    lane_word[j*PSUM_W +: PSUM_W] = octet_sum[j];
                end
                default: begin
                    lane_word[j*PSUM_W +: PSUM_W] = '0;
                end
            endcase
        end
    end

    // word register, loaded only for issued beats
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            lane_data <= lane_word;
        end
    end

    // tags ride along with the word, one stage
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
            sum_last  <= 1'b0;
        end else begin
            sum_valid <= issue_valid;
            sum_last  <= issue_valid && issue_last;
        end
    end

endmodule

/* source/su_result_writer.sv */
`timescale 1ns/1ps

module su_result_writer (
    input  logic                          clk,
    input  logic                          reset,
    input  su_pkg::gbf_word_t             lane_data,
    input  logic                          sum_valid,
    input  logic                          sum_last,
    output su_pkg::gbf_word_t             out_data,
    output logic                          psum_gbf_w_en_out,
    output logic [su_pkg::GBF_ADDR_W-1:0] psum_gbf_w_addr,
    output logic                          psum_gbf_w_num,
    output logic                          su_add_finish
);

    import su_pkg::*;

    logic addr_wrap;

    // pointer sits on the last word of the current buffer
    assign addr_wrap = (psum_gbf_w_addr == GBF_ADDR_W'(GBF_DEPTH-1));

    // buffer word, follows the tree output by one cycle
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            out_data <= lane_data;
        end
    end

    // write strobe and finish pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            psum_gbf_w_en_out <= 1'b0;
            su_add_finish     <= 1'b0;
        end else begin
            psum_gbf_w_en_out <= sum_valid;
            su_add_finish     <= sum_valid && sum_last;  // lands on the last write
        end
    end

    // write pointer steps once a write has gone out
    // the buffer select survives between runs, so a new run continues
    // where the previous one stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            psum_gbf_w_addr <= '0;
            psum_gbf_w_num  <= 1'b0;
        end else if (psum_gbf_w_en_out) begin
            if (addr_wrap) begin
                psum_gbf_w_addr <= '0;
                psum_gbf_w_num  <= ~psum_gbf_w_num;  // switch buffer 0 <-> 1
            end else begin
                psum_gbf_w_addr <= psum_gbf_w_addr + 1'b1;
            end
        end
    end

endmodule

/* source/su_adder.sv */
`timescale 1ns/1ps

module su_adder (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [su_pkg::PE_COUNT*su_pkg::PSUM_W-1:0] psum_out,
    input  logic                                     pe_psum_finish,
    input  logic [4:0]                               irrel_num,
    output logic [su_pkg::RF_ADDR_W-1:0]             psum_rf_addr,
    output su_pkg::gbf_word_t                        out_data,
    output logic                                     psum_gbf_w_en_out,
    output logic [su_pkg::GBF_ADDR_W-1:0]            psum_gbf_w_addr,
    output logic                                     psum_gbf_w_num,
    output logic                                     su_add_finish,
    output logic                                     busy
);

    import su_pkg::*;

    group_mode_t       group_mode;
    logic              issue_valid;
    logic [BEAT_W-1:0] issue_beat;
    logic              issue_last;
    gbf_word_t         lane_data;
    logic              sum_valid;
    logic              sum_last;

    // run control, one beat per cycle
    su_beat_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .pe_psum_finish (pe_psum_finish),
        .irrel_num      (irrel_num),
        .busy           (busy),
        .psum_rf_addr   (psum_rf_addr),
        .group_mode     (group_mode),
        .issue_valid    (issue_valid),
        .issue_beat     (issue_beat),
        .issue_last     (issue_last)
    );

    su_adder_tree u_tree (
        .clk         (clk),
        .reset       (reset),
        .psum_out    (psum_out),
        .group_mode  (group_mode),
        .issue_valid (issue_valid),
        .issue_beat  (issue_beat),
        .issue_last  (issue_last),
        .lane_data   (lane_data),
        .sum_valid   (sum_valid),
        .sum_last    (sum_last)
    );

    // psum global buffer side
    su_result_writer u_wr (
        .clk               (clk),
        .reset             (reset),
        .lane_data         (lane_data),
        .sum_valid         (sum_valid),
        .sum_last          (sum_last),
        .out_data          (out_data),
        .psum_gbf_w_en_out (psum_gbf_w_en_out),
        .psum_gbf_w_addr   (psum_gbf_w_addr),
        .psum_gbf_w_num    (psum_gbf_w_num),
        .su_add_finish     (su_add_finish)
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);  // five edges in reset
        @(negedge clk);
        reset = 1'b0;
    end

    always #10 clk = ~clk;  // 20 ns period

endmodule

/* dv/su_adder_sva.sv */
`timescale 1ns/1ps

module su_adder_sva (
    input logic                          clk,
    input logic                          reset,
    input logic                          busy,
    input logic [su_pkg::RF_ADDR_W-1:0]  psum_rf_addr,
    input logic                          psum_gbf_w_en_out,
    input logic [su_pkg::GBF_ADDR_W-1:0] psum_gbf_w_addr,
    input logic                          su_add_finish
);

    // write strobe trails busy by two stages
    a_no_write_idle: assert property (@(posedge clk) disable iff (reset)
        (!busy && !$past(busy) && !$past(busy, 2)) |-> !psum_gbf_w_en_out)
        else $error("buffer write while the reducer is idle");

    a_finish_on_write: assert property (@(posedge clk) disable iff (reset)
        su_add_finish |-> psum_gbf_w_en_out)
        else $error("finish pulse without a buffer write");

    a_addr_step: assert property (@(posedge clk) disable iff (reset)
        psum_gbf_w_en_out |=> (psum_gbf_w_addr == $past(psum_gbf_w_addr) + 5'd1))
        else $error("write address did not step after a write");

    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        !psum_gbf_w_en_out |=> $stable(psum_gbf_w_addr))
        else $error("write address moved without a write");

    a_rf_addr_busy: assert property (@(posedge clk) disable iff (reset)
        !$stable(psum_rf_addr) |-> $past(busy))
        else $error("rf address changed outside a run");

endmodule

/* dv/tb_su_adder.sv */
`timescale 1ns/1ps

module tb_su_adder;

    import su_pkg::*;

    localparam int RF_ROWS      = 1 << RF_ADDR_W;
    localparam int TOTAL_WRITES = 16 + 8 + 4 + 16 + 16 + 4 + 8;  // runs 2,4,8,2,2,8,4
    // reset, idle check, every write plus about four cycles of overhead per run
    localparam int TEST_CYCLES    = 5 + 10 + TOTAL_WRITES + 7 * 4 + 8;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    typedef struct {
        gbf_word_t             data;
        logic [GBF_ADDR_W-1:0] addr;
        logic                  num;
        logic                  last;
    } exp_write_t;

    logic                         clk;
    logic                         reset;
    logic [PE_COUNT*PSUM_W-1:0]   psum_out;
    logic                         pe_psum_finish;
    logic [4:0]                   irrel_num;
    logic [RF_ADDR_W-1:0]         psum_rf_addr;
    gbf_word_t                    out_data;
    logic                         psum_gbf_w_en_out;
    logic [GBF_ADDR_W-1:0]        psum_gbf_w_addr;
    logic                         psum_gbf_w_num;
    logic                         su_add_finish;
    logic                         busy;

    logic [PE_COUNT*PSUM_W-1:0]   psum_mem [RF_ROWS];
    exp_write_t                   exp_q [$];
    logic [GBF_ADDR_W-1:0]        model_addr = '0;
    logic                         model_num = 1'b0;
    int                           model_toggles = 0;
    int                           toggle_cnt = 0;
    logic                         seen_num = 1'b0;
    int                           cycle_cnt = 0;

    tb_clock clock0 (.clk(clk), .reset(reset));

    su_adder dut0 (
        .clk               (clk),
        .reset             (reset),
        .psum_out          (psum_out),
        .pe_psum_finish    (pe_psum_finish),
        .irrel_num         (irrel_num),
        .psum_rf_addr      (psum_rf_addr),
        .out_data          (out_data),
        .psum_gbf_w_en_out (psum_gbf_w_en_out),
        .psum_gbf_w_addr   (psum_gbf_w_addr),
        .psum_gbf_w_num    (psum_gbf_w_num),
        .su_add_finish     (su_add_finish),
        .busy              (busy)
    );

    bind su_adder su_adder_sva sva0 (
        .clk               (clk),
        .reset             (reset),
        .busy              (busy),
        .psum_rf_addr      (psum_rf_addr),
        .psum_gbf_w_en_out (psum_gbf_w_en_out),
        .psum_gbf_w_addr   (psum_gbf_w_addr),
        .su_add_finish     (su_add_finish)
    );

    // pe array model shows the row of the current rf address at once
    assign psum_out = psum_mem[psum_rf_addr];

    task automatic abort_sim();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        abort_sim();
    endtask

    task automatic check_value(input string name, input gbf_word_t got, input gbf_word_t exp);
        if (got !== exp) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            abort_sim();
        end
    endtask

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // group g of size G adds pes g*G .. g*G+G-1
    // lane j of beat k holds group k*32+j
    function automatic gbf_word_t expected_word(input logic [PE_COUNT*PSUM_W-1:0] row,
                                                input int size, input int beat);
        gbf_word_t w;
        psum_t     acc;
        int        g;
        w = '0;
        for (int j = 0; j < GBF_LANES; j++) begin
            g   = beat * GBF_LANES + j;
            acc = '0;
            for (int p = 0; p < size; p++) begin
                acc = acc + row[(g * size + p) * PSUM_W +: PSUM_W];  // wraps at 16 bits
            end
            w[j*PSUM_W +: PSUM_W] = acc;
        end
        return w;
    endfunction

    task automatic fill_memory();
        logic [31:0] state;
        state = 32'h7640_b3eb;
        for (int r = 0; r < RF_ROWS; r++) begin
            for (int b = 0; b < PE_COUNT * PSUM_W; b++) begin
                state          = lfsr_step(state);
                psum_mem[r][b] = state[0];
            end
        end
    endtask

    // queue the writes of one run in address then beat order
    task automatic expect_run(input int size);
        exp_write_t item;
        int         beats;
        beats = 8 / size;
        for (int a = 0; a < RF_ROWS; a++) begin
            for (int k = 0; k < beats; k++) begin
                item.data = expected_word(psum_mem[a], size, k);
                item.addr = model_addr;
                item.num  = model_num;
                item.last = (a == RF_ROWS - 1) && (k == beats - 1);
                exp_q.push_back(item);
                if (model_addr == GBF_ADDR_W'(GBF_DEPTH - 1)) begin
                    model_addr = '0;
                    model_num  = ~model_num;
                    model_toggles++;
                end else begin
                    model_addr = model_addr + GBF_ADDR_W'(1);
                end
            end
        end
    endtask

    task automatic run_reduce(input int size, input bit extra_pulse);
        int beats;
        beats = 8 / size;
        expect_run(size);
        irrel_num      = 5'(size);
        pe_psum_finish = 1'b1;
        @(negedge clk);
        pe_psum_finish = 1'b0;
        check_value("busy", GBF_W'(busy), GBF_W'(1));
        check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), '0);
        @(negedge clk);
        check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), '0);
        @(negedge clk);
        check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), GBF_W'(1));
        // strobe has to stay up for the whole run
        for (int i = 1; i < 4 * beats; i++) begin
            pe_psum_finish = extra_pulse && (i == 1);  // restart attempt mid run
            @(negedge clk);
            check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), GBF_W'(1));
        end
        pe_psum_finish = 1'b0;
        @(negedge clk);
        check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), '0);
        check_value("busy", GBF_W'(busy), '0);
    endtask

    // writes are compared at the falling edge where outputs are stable
    always @(negedge clk) begin
        exp_write_t item;
        if (!reset) begin
            if (psum_gbf_w_en_out) begin
                if (exp_q.size() == 0) begin
                    fail_run("buffer write with no write expected");
                end else begin
                    item = exp_q.pop_front();
                    check_value("out_data", out_data, item.data);
                    check_value("psum_gbf_w_addr", GBF_W'(psum_gbf_w_addr), GBF_W'(item.addr));
                    check_value("psum_gbf_w_num", GBF_W'(psum_gbf_w_num), GBF_W'(item.num));
                    check_value("su_add_finish", GBF_W'(su_add_finish), GBF_W'(item.last));
                end
            end else begin
                check_value("su_add_finish", GBF_W'(su_add_finish), '0);
            end
            if (psum_gbf_w_num != seen_num) begin
                toggle_cnt++;
                seen_num = psum_gbf_w_num;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the test did not finish in time");
        end
    end

    initial begin
        pe_psum_finish = 1'b0;
        irrel_num      = 5'd0;
        fill_memory();
        @(negedge clk);
        while (reset) @(negedge clk);

        check_value("busy", GBF_W'(busy), '0);
        check_value("psum_gbf_w_en_out", GBF_W'(psum_gbf_w_en_out), '0);
        check_value("su_add_finish", GBF_W'(su_add_finish), '0);
        check_value("psum_gbf_w_addr", GBF_W'(psum_gbf_w_addr), '0);
        check_value("psum_gbf_w_num", GBF_W'(psum_gbf_w_num), '0);
        check_value("psum_rf_addr", GBF_W'(psum_rf_addr), '0);

        // size 5 is not supported so the pulse must be dropped
        irrel_num      = 5'd5;
        pe_psum_finish = 1'b1;
        @(negedge clk);
        pe_psum_finish = 1'b0;
        repeat (8) begin
            check_value("busy", GBF_W'(busy), '0);
            @(negedge clk);
        end

        run_reduce(2, 1'b0);
        run_reduce(4, 1'b0);
        run_reduce(8, 1'b0);
        run_reduce(2, 1'b0);  // pointer crosses the end of buffer 0 here
        run_reduce(2, 1'b0);
        run_reduce(8, 1'b0);
        run_reduce(4, 1'b1);

        repeat (4) @(negedge clk);
        check_value("psum_gbf_w_addr", GBF_W'(psum_gbf_w_addr), GBF_W'(model_addr));
        check_value("psum_gbf_w_num", GBF_W'(psum_gbf_w_num), GBF_W'(model_num));
        check_value("psum_gbf_w_num toggles", GBF_W'(toggle_cnt), GBF_W'(model_toggles));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* verilog.f */
source/su_pkg.sv
source/su_beat_sequencer.sv
source/su_adder_tree.sv
source/su_result_writer.sv
source/su_adder.sv
dv/tb_clock.sv
dv/su_adder_sva.sv
dv/tb_su_adder.sv

/* run.sh */
#!/usr/bin/env bash
# builds the su_adder testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_su_adder \
    -f verilog.f \
    -o tb_su_adder \
    && ./obj_dir/tb_su_adder | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
    && echo "su_adder test passed" \
    || { echo "su_adder test failed"; exit 1; }
